//--- logic/trackPkg.sv
// Shared sizes and record types for the read-request tracker.
// Every tracker module pulls these in by a wildcard import in its header.
// Host and memory traffic travel as the packed structs defined here.

package trackPkg;

    // Number of heap slots, one per outstanding read
    localparam int TRACK_ENTRIES = 16;
    // Slot index width, which is also the tag width on the memory side
    localparam int TAG_BITS = $clog2(TRACK_ENTRIES);
    localparam int ADDR_BITS = 16;
    localparam int COOKIE_BITS = 8;
    localparam int DATA_BITS = 32;

    typedef logic [TAG_BITS-1:0] tagT;

    // Host request, kept unchanged in the heap until its response returns
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [COOKIE_BITS-1:0] cookie;
    } hostReqT;

    // Tagged read sent to memory
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        tagT tag;
    } memReqT;

    // Memory reply, tag names the heap slot of the request
    typedef struct packed {
        tagT tag;
        logic [DATA_BITS-1:0] data;
    } memRspT;

    // Reply to the host with the request fields restored
    typedef struct packed {
        logic [COOKIE_BITS-1:0] cookie;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] data;
    } hostRspT;

endpackage

//--- logic/trackHeap.sv
// Round-robin heap holding the host request of every outstanding read.
// Slots are handed out strictly in turn, so the heap reports full as soon
// as the next slot in turn is busy, even when other slots are free.
// Records are written at allocation and read back one cycle after readReq.

module trackHeap
    import trackPkg::*;
(
    input  logic clk,
    input  logic resetb,
    // Allocation side
    input  logic enq,
    input  hostReqT enqData,
    output logic notFull,
    output tagT allocIdx,
    // Lookup side, readRsp follows readReq by one cycle
    input  tagT readReq,
    output hostReqT readRsp,
    // Release of a slot once its response is back
    input  logic free,
    input  tagT freeIdx
);

    // One bit per slot, set while the slot may be allocated
    logic [TRACK_ENTRIES-1:0] notBusy;
    // Slot that the next allocation will take
    tagT nextAlloc;
    // Request records indexed by tag
    hostReqT mem [0:TRACK_ENTRIES-1];

    // Only the slot in turn matters for allocation
    assign notFull = notBusy[nextAlloc];
    assign allocIdx = nextAlloc;

    // Allocation pointer steps once per accepted request
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            nextAlloc <= '0;
        end
        else if (enq)
        begin
            if (nextAlloc == tagT'(TRACK_ENTRIES - 1))
                nextAlloc <= '0;
            else
                nextAlloc <= nextAlloc + 1'b1;
        end
    end

    // Record storage with a registered read port
    always_ff @(posedge clk)
    begin
        readRsp <= mem[readReq];
        if (enq)
        begin
            mem[allocIdx] <= enqData;
        end
    end

    // Free list, a released slot is available from the next cycle on
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            notBusy <= '1;
        end
        else
        begin
            if (enq)
            begin
                notBusy[allocIdx] <= 1'b0;
            end
            if (free)
            begin
                notBusy[freeIdx] <= 1'b1;
            end
        end
    end

    // The issue side must hold off allocation while the slot in turn is busy
    enqWhenFull: assert property (@(posedge clk) disable iff (!resetb)
        enq |-> notFull)
        else $error("trackHeap: enq while full");

    // A memory response may only name a slot that holds a live request
    freeOfIdle: assert property (@(posedge clk) disable iff (!resetb)
        free |-> !notBusy[freeIdx])
        else $error("trackHeap: free of idle slot %0d", freeIdx);

endmodule

//--- logic/reqIssue.sv
// Issue stage of the tracker.
// Takes host requests while the heap has the slot in turn free, allocates
// that slot and sends the tagged read to memory one cycle later.

module reqIssue
    import trackPkg::*;
(
    input  logic clk,
    input  logic resetb,
    input  logic hostReqValid,
    input  hostReqT hostReq,
    // Heap allocation status
    input  logic notFull,
    input  tagT allocIdx,
    output logic enq,
    // Host flow control
    output logic reqReady,
    // Registered request to memory
    output logic memReqValid,
    output memReqT memReq
);

    // The host sees heap space directly as its ready level
    assign reqReady = notFull;

    // A request is taken only when the slot in turn is free
    assign enq = hostReqValid && notFull;

    // Valid strobe is control state and clears on reset
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            memReqValid <= 1'b0;
        end
        else
        begin
            memReqValid <= enq;
        end
    end

    // Address and tag are loaded only for an accepted request
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            memReq.addr <= hostReq.addr;
            memReq.tag <= allocIdx;
        end
    end

    // A host strobe while reqReady is low would be dropped
    hostOverrun: assert property (@(posedge clk) disable iff (!resetb)
        hostReqValid |-> notFull)
        else $error("reqIssue: host request while not ready");

endmodule

//--- logic/rspMatch.sv
// Response stage of the tracker.
// A memory response starts the heap lookup and frees its slot in the same
// cycle. The data waits one cycle for the heap record, then the cookie and
// address of the original request are merged into the host response.
// Responses leave in the order memory returned them.

module rspMatch
    import trackPkg::*;
(
    input  logic clk,
    input  logic resetb,
    input  logic memRspValid,
    input  memRspT memRsp,
    // Heap lookup, readRsp arrives the cycle after readReq
    output tagT readReq,
    input  hostReqT readRsp,
    // Slot release
    output logic free,
    output tagT freeIdx,
    // Response to the host
    output logic hostRspValid,
    output hostRspT hostRsp
);

    // Response data held while the heap read completes
    logic [DATA_BITS-1:0] rspData;
    // Set for one cycle after each memory response
    logic rspValid;

    // Lookup and release both use the response tag
    assign readReq = memRsp.tag;
    assign free = memRspValid;
    assign freeIdx = memRsp.tag;

    // Valid bit is control and clears on reset
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rspValid <= 1'b0;
        end
        else
        begin
            rspValid <= memRspValid;
        end
    end

    // Data is captured only for a live response
    always_ff @(posedge clk)
    begin
        if (memRspValid)
        begin
            rspData <= memRsp.data;
        end
    end

    // Freeing the slot at the response edge is safe here
    // because a reuse cannot write the heap before the read below has been sampled
    assign hostRspValid = rspValid;
    assign hostRsp.cookie = readRsp.cookie;
    assign hostRsp.addr = readRsp.addr;
    assign hostRsp.data = rspData;

    // Back-to-back host responses need back-to-back memory responses
    rspPacing: assert property (@(posedge clk) disable iff (!resetb)
        hostRspValid && $past(hostRspValid) |->
            $past(memRspValid) && $past(memRspValid, 2))
        else $error("rspMatch: host response without matching memory response");

endmodule

//--- logic/readTracker.sv
// Top level of the read-request tracker.
// Host requests are tagged with a heap slot and sent to memory, and
// out-of-order memory responses are matched back to their requests.
// This level only wires the issue stage, the heap and the match stage.

module readTracker
    import trackPkg::*;
(
    input  logic clk,
    input  logic resetb,
    input  logic hostReqValid,
    input  hostReqT hostReq,
    output logic reqReady,
    output logic memReqValid,
    output memReqT memReq,
    input  logic memRspValid,
    input  memRspT memRsp,
    output logic hostRspValid,
    output hostRspT hostRsp
);

    // Allocation between the issue stage and the heap
    logic enq;
    logic notFull;
    tagT allocIdx;
    // Lookup and release between the match stage and the heap
    tagT readReq;
    hostReqT readRsp;
    logic free;
    tagT freeIdx;

    reqIssue reqIssue_i (
        .clk(clk),
        .resetb(resetb),
        .hostReqValid(hostReqValid),
        .hostReq(hostReq),
        .notFull(notFull),
        .allocIdx(allocIdx),
        .enq(enq),
        .reqReady(reqReady),
        .memReqValid(memReqValid),
        .memReq(memReq)
    );

    // The host request itself is the stored record
    trackHeap trackHeap_i (
        .clk(clk),
        .resetb(resetb),
        .enq(enq),
        .enqData(hostReq),
        .notFull(notFull),
        .allocIdx(allocIdx),
        .readReq(readReq),
        .readRsp(readRsp),
        .free(free),
        .freeIdx(freeIdx)
    );

    rspMatch rspMatch_i (
        .clk(clk),
        .resetb(resetb),
        .memRspValid(memRspValid),
        .memRsp(memRsp),
        .readReq(readReq),
        .readRsp(readRsp),
        .free(free),
        .freeIdx(freeIdx),
        .hostRspValid(hostRspValid),
        .hostRsp(hostRsp)
    );

endmodule

//--- tests/readTrackerTb.sv
// Testbench for the read tracker, playing the host and an out-of-order memory.
// Steps come from tests/trackInput.txt: a burst of requests, then the memory
// responses in the order the file gives, each with its data word.
// Addresses and cookies are pseudo-random and are checked against what was sent.

module readTrackerTb
    import trackPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic resetb;
    logic hostReqValid;
    hostReqT hostReq;
    logic reqReady;
    logic memReqValid;
    memReqT memReq;
    logic memRspValid;
    memRspT memRsp;
    logic hostRspValid;
    hostRspT hostRsp;

    // Raw words of the input file read once at time zero
    logic [31:0] stim [0:255];
    // Per-step record of what the host sent and which tag memory saw
    hostReqT reqSent [0:15];
    tagT stepTag [0:15];
    int order [0:15];
    logic [31:0] stepData [0:15];
    // Slot occupancy as the round-robin rules predict it
    logic [TRACK_ENTRIES-1:0] busyModel;
    logic [31:0] rngState;
    logic readyFlag;
    tagT predTag;
    int ptr, count, k, reqTotal, testNum, errBefore;
    int checkCount, errorCount, cycleLimit;
    int cycleCount = 0;

    readTracker dut_i (
        .clk(clk),
        .resetb(resetb),
        .hostReqValid(hostReqValid),
        .hostReq(hostReq),
        .reqReady(reqReady),
        .memReqValid(memReqValid),
        .memReq(memReq),
        .memRspValid(memRspValid),
        .memRsp(memRsp),
        .hostRspValid(hostRspValid),
        .hostRsp(hostRsp)
    );

    always #50 clk = ~clk;

    // Stops a stalled run at a limit worked out from the file length
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit)
        begin
            $display("Timeout after %0d cycles, the test steps did not finish", cycleCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        begin
            y = x ^ (x << 13);
            y = y ^ (y >> 17);
            y = y ^ (y << 5);
            return y;
        end
    endfunction

    task automatic compareSignal(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        begin
            checkCount++;
            if (got !== expected)
            begin
                errorCount++;
                $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            end
        end
    endtask

    // Outputs are sampled and inputs changed 5 ns after each rising edge
    task automatic nextCycle;
        begin
            @(posedge clk);
            #5;
        end
    endtask

    initial
    begin
        resetb = 1'b0;
        hostReqValid = 1'b0;
        hostReq = '0;
        memRspValid = 1'b0;
        memRsp = '0;
        busyModel = '0;
        rngState = 32'hc2b121cf;
        checkCount = 0;
        errorCount = 0;
        reqTotal = 0;
        testNum = 0;
        $readmemh("tests/trackInput.txt", stim);

        // Two cycles per request and response plus a margin for reset and idle cycles
        cycleLimit = 40;
        ptr = 0;
        while (stim[ptr] != 0 && stim[ptr] <= 32'(TRACK_ENTRIES))
        begin
            cycleLimit += 2 * int'(stim[ptr]) + 4;
            ptr += 2 + 2 * int'(stim[ptr]);
        end

        repeat (8) @(posedge clk);
        #5 resetb = 1'b1;
        // Idle after reset with every slot free and nothing in flight
        repeat (2)
        begin
            nextCycle();
            compareSignal("reqReady", 64'(reqReady), 64'(1'b1));
            compareSignal("memReqValid", 64'(memReqValid), 64'(1'b0));
            compareSignal("hostRspValid", 64'(hostRspValid), 64'(1'b0));
        end

        ptr = 0;
        while (stim[ptr] != 0 && stim[ptr] <= 32'(TRACK_ENTRIES))
        begin
            count = int'(stim[ptr]);
            readyFlag = stim[ptr + 1][0];
            for (int i = 0; i < count; i++)
            begin
                order[i] = int'(stim[ptr + 2 + i]);
                stepData[i] = stim[ptr + 2 + count + i];
            end
            ptr += 2 + 2 * count;
            testNum++;
            errBefore = errorCount;

            // Requests go out one per cycle and each shows up at memory a cycle later
            for (int i = 0; i < count; i++)
            begin
                compareSignal("reqReady", 64'(reqReady), 64'(1'b1));
                rngState = xorshift32(rngState);
                hostReqValid = 1'b1;
                hostReq = rngState[23:0];
                reqSent[i] = rngState[23:0];
                predTag = tagT'(reqTotal % TRACK_ENTRIES);
                reqTotal++;
                nextCycle();
                compareSignal("memReqValid", 64'(memReqValid), 64'(1'b1));
                compareSignal("memReq.addr", 64'(memReq.addr), 64'(reqSent[i].addr));
                compareSignal("memReq.tag", 64'(memReq.tag), 64'(predTag));
                compareSignal("hostRspValid", 64'(hostRspValid), 64'(1'b0));
                stepTag[i] = memReq.tag;
                busyModel[memReq.tag] = 1'b1;
            end
            hostReqValid = 1'b0;
            compareSignal("reqReady after requests", 64'(reqReady), 64'(readyFlag));

            // Memory answers in file order using the tags it recorded
            for (int j = 0; j < count; j++)
            begin
                k = order[j];
                memRspValid = 1'b1;
                memRsp.tag = stepTag[k];
                memRsp.data = stepData[j];
                nextCycle();
                compareSignal("hostRspValid", 64'(hostRspValid), 64'(1'b1));
                compareSignal("hostRsp.cookie", 64'(hostRsp.cookie), 64'(reqSent[k].cookie));
                compareSignal("hostRsp.addr", 64'(hostRsp.addr), 64'(reqSent[k].addr));
                compareSignal("hostRsp.data", 64'(hostRsp.data), 64'(stepData[j]));
                compareSignal("memReqValid", 64'(memReqValid), 64'(1'b0));
                busyModel[stepTag[k]] = 1'b0;
                // Ready follows only the slot in turn, not the free count
                predTag = tagT'(reqTotal % TRACK_ENTRIES);
                compareSignal("reqReady", 64'(reqReady), 64'(!busyModel[predTag]));
            end
            // The next step's first request goes out in the very next cycle
            memRspValid = 1'b0;
            $display("Test %0d: %0d requests and responses, %0s", testNum, count,
                     (errorCount == errBefore) ? "ok" : "mismatches");
        end

        if (testNum == 0)
        begin
            errorCount++;
            $display("No test steps could be read from tests/trackInput.txt");
        end
        nextCycle();
        compareSignal("memReqValid", 64'(memReqValid), 64'(1'b0));
        compareSignal("hostRspValid", 64'(hostRspValid), 64'(1'b0));

        $display("Tests %0d, checks %0d, errors %0d", testNum, checkCount, errorCount);
        if (errorCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- readTracker.f
logic/trackPkg.sv
logic/trackHeap.sv
logic/reqIssue.sv
logic/rspMatch.sv
logic/readTracker.sv
tests/readTrackerTb.sv

//--- run.sh
#!/bin/sh
# Builds the tracker testbench with Verilator and runs it from the project root.
# The run fails when the build fails, the simulation stops early or the log holds the fail line.

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module readTrackerTb -f readTracker.f -o readTrackerSim > build.log 2>&1 \
    && ./obj_dir/readTrackerSim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "=== FAIL ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- tests/trackInput.txt
// Test steps for the read tracker, all numbers in hex, one step after the other.
// Each step: request count, expected reqReady after the requests, then one response
// order (request numbers within the step), then one data word per response. Count 0 ends.
3 1
2 0 1
a5a50001 0badf00d 12345678
10 0
5 3 f 0 1 2 4 6 7 8 9 a b c d e
11110000 22220001 33330002 44440003 55550004 66660005 77770006 88880007
99990008 aaaa0009 bbbb000a cccc000b dddd000c eeee000d ffff000e 0000000f
10 0
1 2 3 4 5 6 7 8 9 a b c d e f 0
c0de0000 c0de0101 c0de0202 c0de0303 c0de0404 c0de0505 c0de0606 c0de0707
c0de0808 c0de0909 c0de0a0a c0de0b0b c0de0c0c c0de0d0d c0de0e0e c0de0f0f
5 1
4 1 3 0 2
deadbeef feedface 01020304 f0e0d0c0 80000001
10 0
f e d c b a 9 8 7 6 5 4 3 2 1 0
5a5a5a5a a5a5a5a5 3c3c3c3c c3c3c3c3 0f0f0f0f f0f0f0f0 13572468 86427531
00000000 ffffffff 7fffffff 80000000 01234567 89abcdef fedcba98 76543210
1 1
0
abcdef01
a 1
9 2 7 0 5 3 8 1 6 4
10101010 20202020 30303030 40404040 50505050 60606060 70707070 80808080
90909090 a0a0a0a0
0
